// File: common/book_params.svh
//////////////////////////////
// book sizes and field widths
// BOOK_STOCK_W must cover BOOK_NUM_STOCKS
//////////////////////////////
`ifndef BOOK_PARAMS_SVH
`define BOOK_PARAMS_SVH

// instruments and order slots per side
`define BOOK_NUM_STOCKS 4
`define BOOK_DEPTH      10

// field widths
`define BOOK_STOCK_W    2
`define BOOK_QTY_W      16
`define BOOK_PRICE_W    32
`define BOOK_ID_W       32

`endif

// File: common/order_book_pkg.sv
//////////////////////////////
// shared types of the order book
//////////////////////////////
`default_nettype none

`include "book_params.svh"

package order_book_pkg;

    // 1 means buy
    typedef enum logic {
        SIDE_ASK = 1'b0,
        SIDE_BID = 1'b1
    } side_t;

    typedef enum logic [1:0] {
        OP_ADD     = 2'd0,
        OP_CANCEL  = 2'd1,
        OP_EXECUTE = 2'd2
    } op_t;

    typedef enum logic [1:0] {
        ST_OK        = 2'd0,
        ST_NOT_FOUND = 2'd1,
        ST_BOOK_FULL = 2'd2
    } status_t;

    // commands to one side's storage
    typedef enum logic [1:0] {
        SIDE_NONE      = 2'd0,
        SIDE_APPEND    = 2'd1,
        SIDE_DECREMENT = 2'd2,
        SIDE_REMOVE    = 2'd3
    } side_op_t;

    typedef struct packed {
        side_t                    side;
        logic [`BOOK_STOCK_W-1:0] stock_id;
        op_t                      op;
        logic [`BOOK_QTY_W-1:0]   quantity;
        logic [`BOOK_PRICE_W-1:0] price;
        logic [`BOOK_ID_W-1:0]    order_id;
    } order_req_t;

    // one resting order, one slot
    typedef struct packed {
        logic [`BOOK_QTY_W-1:0]   quantity;
        logic [`BOOK_PRICE_W-1:0] price;
        logic [`BOOK_ID_W-1:0]    order_id;
    } book_entry_t;

    typedef struct packed {
        logic [`BOOK_STOCK_W-1:0] stock_id;
        status_t                  status;
        logic [`BOOK_PRICE_W-1:0] best_bid;
        logic [`BOOK_PRICE_W-1:0] best_ask;
    } book_resp_t;

endpackage

`default_nettype wire

// File: book/book_side_mem.sv
//////////////////////////////
// one book side, all instruments
// append to a full side is not guarded
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "book_params.svh"

module book_side_mem (
    input  logic                           i_clk,
    input  logic                           i_reset_n,
    input  order_book_pkg::side_op_t       i_cmd,
    input  logic [`BOOK_STOCK_W-1:0]       i_stock,
    input  logic [$clog2(`BOOK_DEPTH)-1:0] i_slot,
    input  order_book_pkg::book_entry_t    i_entry,
    input  logic [`BOOK_QTY_W-1:0]         i_dec_qty,
    input  logic [`BOOK_ID_W-1:0]          i_match_id,
    input  logic [$clog2(`BOOK_DEPTH)-1:0] i_scan_slot,
    output logic                           o_hit,
    output logic [$clog2(`BOOK_DEPTH)-1:0] o_hit_slot,
    output logic [`BOOK_QTY_W-1:0]         o_hit_qty,
    output logic                           o_full,
    output order_book_pkg::book_entry_t    o_scan_entry,
    output logic                           o_scan_valid
);
    import order_book_pkg::*;

    localparam int SLOT_W = $clog2(`BOOK_DEPTH);
    localparam int CNT_W  = $clog2(`BOOK_DEPTH + 1);

    // occupied slots are always 0 .. fill-1
    book_entry_t      mem  [`BOOK_NUM_STOCKS][`BOOK_DEPTH];
    logic [CNT_W-1:0] fill [`BOOK_NUM_STOCKS];

    // parallel id match, lowest slot wins
    always_comb begin
        o_hit      = 1'b0;
        o_hit_slot = '0;
        o_hit_qty  = '0;
        for (int s = `BOOK_DEPTH - 1; s >= 0; s--) begin
            if (CNT_W'(s) < fill[i_stock] && mem[i_stock][s].order_id == i_match_id) begin
                o_hit      = 1'b1;
                o_hit_slot = SLOT_W'(s);
                o_hit_qty  = mem[i_stock][s].quantity;
            end
        end
    end

    assign o_full       = (fill[i_stock] == CNT_W'(`BOOK_DEPTH));
    assign o_scan_entry = mem[i_stock][i_scan_slot];
    assign o_scan_valid = (CNT_W'(i_scan_slot) < fill[i_stock]);

    always_ff @(posedge i_clk) begin
        case (i_cmd)
            SIDE_APPEND: begin
                mem[i_stock][fill[i_stock]] <= i_entry;
            end
            SIDE_DECREMENT: begin
                mem[i_stock][i_slot].quantity <= mem[i_stock][i_slot].quantity - i_dec_qty;
            end
            SIDE_REMOVE: begin
                // close the gap in one cycle
                for (int s = 0; s < `BOOK_DEPTH - 1; s++) begin
                    if (SLOT_W'(s) >= i_slot) begin
                        mem[i_stock][s] <= mem[i_stock][s + 1];
                    end
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            for (int k = 0; k < `BOOK_NUM_STOCKS; k++) begin
                fill[k] <= '0;
            end
        end else if (i_cmd == SIDE_APPEND) begin
            fill[i_stock] <= fill[i_stock] + 1'b1;
        end else if (i_cmd == SIDE_REMOVE) begin
            fill[i_stock] <= fill[i_stock] - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: book/best_price_tracker.sv
//////////////////////////////
// best price per instrument, one side
// rescan takes BOOK_DEPTH cycles
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "book_params.svh"

module best_price_tracker #(
    parameter bit IS_BID = 1'b1
) (
    input  logic                           i_clk,
    input  logic                           i_reset_n,
    input  logic [`BOOK_STOCK_W-1:0]       i_stock,
    input  logic                           i_add,
    input  logic [`BOOK_PRICE_W-1:0]       i_add_price,
    input  logic                           i_rescan,
    input  order_book_pkg::book_entry_t    i_scan_entry,
    input  logic                           i_scan_valid,
    output logic [$clog2(`BOOK_DEPTH)-1:0] o_scan_slot,
    output logic                           o_scan_done,
    output logic [`BOOK_PRICE_W-1:0]       o_best
);
    import order_book_pkg::*;

    localparam int SLOT_W = $clog2(`BOOK_DEPTH);
    // bids empty at 0, asks empty at all ones
    localparam logic [`BOOK_PRICE_W-1:0] EMPTY = {`BOOK_PRICE_W{!IS_BID}};

    logic [`BOOK_PRICE_W-1:0] best [`BOOK_NUM_STOCKS];
    logic [`BOOK_PRICE_W-1:0] run_best;
    logic [`BOOK_PRICE_W-1:0] cand;
    logic [SLOT_W-1:0]        scan_cnt;
    logic                     scanning;

    function automatic logic better(input logic [`BOOK_PRICE_W-1:0] a,
                                    input logic [`BOOK_PRICE_W-1:0] b);
        return IS_BID ? (a > b) : (a < b);
    endfunction

    assign cand = (i_scan_valid && better(i_scan_entry.price, run_best)) ?
                  i_scan_entry.price : run_best;

    assign o_scan_slot = scan_cnt;
    assign o_scan_done = scanning && (scan_cnt == SLOT_W'(`BOOK_DEPTH - 1));
    assign o_best      = best[i_stock];

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            scanning <= 1'b0;
            scan_cnt <= '0;
            for (int k = 0; k < `BOOK_NUM_STOCKS; k++) begin
                best[k] <= EMPTY;
            end
        end else begin
            if (i_rescan) begin
                scanning <= 1'b1;
                scan_cnt <= '0;
            end else if (scanning) begin
                scan_cnt <= o_scan_done ? '0 : scan_cnt + 1'b1;
                if (o_scan_done) begin
                    scanning      <= 1'b0;
                    best[i_stock] <= cand;
                end
            end
            if (i_add && better(i_add_price, best[i_stock])) begin
                best[i_stock] <= i_add_price;
            end
        end
    end

    // running best of the walk
    always_ff @(posedge i_clk) begin
        if (i_rescan) begin
            run_best <= EMPTY;
        end else if (scanning) begin
            run_best <= cand;
        end
    end

endmodule

`default_nettype wire

// File: book/book_ctrl.sv
//////////////////////////////
// sequencer, owns both handshakes
// response held until i_resp_ready
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "book_params.svh"

module book_ctrl (
    input  logic                            i_clk,
    input  logic                            i_reset_n,
    input  logic                            i_req_valid,
    input  order_book_pkg::order_req_t      i_req,
    input  logic                            i_resp_ready,
    input  logic                            i_bid_hit,
    input  logic                            i_ask_hit,
    input  logic [$clog2(`BOOK_DEPTH)-1:0]  i_bid_hit_slot,
    input  logic [$clog2(`BOOK_DEPTH)-1:0]  i_ask_hit_slot,
    input  logic [`BOOK_QTY_W-1:0]          i_bid_hit_qty,
    input  logic [`BOOK_QTY_W-1:0]          i_ask_hit_qty,
    input  logic                            i_bid_full,
    input  logic                            i_ask_full,
    input  logic [`BOOK_PRICE_W-1:0]        i_bid_best,
    input  logic [`BOOK_PRICE_W-1:0]        i_ask_best,
    input  logic                            i_bid_scan_done,
    input  logic                            i_ask_scan_done,
    output logic                            o_busy,
    output logic                            o_resp_valid,
    output order_book_pkg::book_resp_t      o_resp,
    output order_book_pkg::side_op_t        o_bid_cmd,
    output order_book_pkg::side_op_t        o_ask_cmd,
    output logic [`BOOK_STOCK_W-1:0]        o_stock,
    output logic [$clog2(`BOOK_DEPTH)-1:0]  o_slot,
    output order_book_pkg::book_entry_t     o_entry,
    output logic [`BOOK_QTY_W-1:0]          o_dec_qty,
    output logic                            o_bid_add,
    output logic                            o_ask_add,
    output logic [`BOOK_PRICE_W-1:0]        o_add_price,
    output logic                            o_bid_rescan,
    output logic                            o_ask_rescan
);
    import order_book_pkg::*;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        APPLY   = 2'd1,
        RESCAN  = 2'd2,
        RESPOND = 2'd3
    } state_t;

    state_t                 state;
    order_req_t             req_q;
    status_t                status_q;
    status_t                status_d;
    side_op_t               cmd;
    logic                   is_bid;
    logic                   apply;
    logic                   hit;
    logic                   full;
    logic [`BOOK_QTY_W-1:0] hit_qty;
    logic                   scan_done;

    assign is_bid    = (req_q.side == SIDE_BID);
    assign apply     = (state == APPLY);
    assign hit       = is_bid ? i_bid_hit : i_ask_hit;
    assign full      = is_bid ? i_bid_full : i_ask_full;
    assign hit_qty   = is_bid ? i_bid_hit_qty : i_ask_hit_qty;
    assign scan_done = is_bid ? i_bid_scan_done : i_ask_scan_done;

    // command and status from op, hit and fill state
    always_comb begin
        cmd      = SIDE_NONE;
        status_d = ST_OK;
        case (req_q.op)
            OP_ADD: begin
                if (full) begin
                    status_d = ST_BOOK_FULL;
                end else begin
                    cmd = SIDE_APPEND;
                end
            end
            OP_CANCEL: begin
                if (hit) begin
                    cmd = SIDE_REMOVE;
                end else begin
                    status_d = ST_NOT_FOUND;
                end
            end
            OP_EXECUTE: begin
                if (!hit) begin
                    status_d = ST_NOT_FOUND;
                end else if (req_q.quantity >= hit_qty) begin
                    cmd = SIDE_REMOVE;
                end else begin
                    cmd = SIDE_DECREMENT;
                end
            end
            default: status_d = ST_NOT_FOUND;
        endcase
    end

    // only the named side sees a command
    assign o_bid_cmd    = (apply && is_bid) ? cmd : SIDE_NONE;
    assign o_ask_cmd    = (apply && !is_bid) ? cmd : SIDE_NONE;
    assign o_bid_add    = apply && is_bid && (cmd == SIDE_APPEND);
    assign o_ask_add    = apply && !is_bid && (cmd == SIDE_APPEND);
    assign o_bid_rescan = apply && is_bid && (cmd == SIDE_REMOVE);
    assign o_ask_rescan = apply && !is_bid && (cmd == SIDE_REMOVE);

    assign o_stock     = req_q.stock_id;
    assign o_slot      = is_bid ? i_bid_hit_slot : i_ask_hit_slot;
    assign o_dec_qty   = req_q.quantity;
    assign o_add_price = req_q.price;
    assign o_entry     = '{quantity: req_q.quantity,
                           price:    req_q.price,
                           order_id: req_q.order_id};

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state        <= IDLE;
            o_busy       <= 1'b0;
            o_resp_valid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (i_req_valid) begin
                        state  <= APPLY;
                        o_busy <= 1'b1;
                    end
                end
                APPLY: state <= (cmd == SIDE_REMOVE) ? RESCAN : RESPOND;
                RESCAN: begin
                    if (scan_done) begin
                        state <= RESPOND;
                    end
                end
                RESPOND: begin
                    // one cycle to let the best price settle, then hold
                    if (!o_resp_valid) begin
                        o_resp_valid <= 1'b1;
                    end else if (i_resp_ready) begin
                        o_resp_valid <= 1'b0;
                        o_busy       <= 1'b0;
                        state        <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == IDLE && i_req_valid) begin
            req_q <= i_req;
        end
        if (apply) begin
            status_q <= status_d;
        end
        if (state == RESPOND && !o_resp_valid) begin
            o_resp <= '{stock_id: req_q.stock_id,
                        status:   status_q,
                        best_bid: i_bid_best,
                        best_ask: i_ask_best};
        end
    end

endmodule

`default_nettype wire

// File: hdl/order_book_top.sv
//////////////////////////////
// limit order book, one op in flight
// removals take BOOK_DEPTH extra cycles
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "book_params.svh"

module order_book_top (
    input  logic                       i_clk,
    input  logic                       i_reset_n,
    input  logic                       i_req_valid,
    input  order_book_pkg::order_req_t i_req,
    input  logic                       i_resp_ready,
    output logic                       o_busy,
    output logic                       o_resp_valid,
    output order_book_pkg::book_resp_t o_resp
);
    import order_book_pkg::*;

    localparam int SLOT_W = $clog2(`BOOK_DEPTH);

    side_op_t                 bid_cmd;
    side_op_t                 ask_cmd;
    logic [`BOOK_STOCK_W-1:0] stock;
    logic [SLOT_W-1:0]        slot;
    book_entry_t              entry;
    logic [`BOOK_QTY_W-1:0]   dec_qty;
    logic                     bid_add;
    logic                     ask_add;
    logic [`BOOK_PRICE_W-1:0] add_price;
    logic                     bid_rescan;
    logic                     ask_rescan;

    logic                     bid_hit;
    logic                     ask_hit;
    logic [SLOT_W-1:0]        bid_hit_slot;
    logic [SLOT_W-1:0]        ask_hit_slot;
    logic [`BOOK_QTY_W-1:0]   bid_hit_qty;
    logic [`BOOK_QTY_W-1:0]   ask_hit_qty;
    logic                     bid_full;
    logic                     ask_full;

    // scan ports between trackers and storage
    logic [SLOT_W-1:0]        bid_scan_slot;
    logic [SLOT_W-1:0]        ask_scan_slot;
    book_entry_t              bid_scan_entry;
    book_entry_t              ask_scan_entry;
    logic                     bid_scan_valid;
    logic                     ask_scan_valid;
    logic                     bid_scan_done;
    logic                     ask_scan_done;
    logic [`BOOK_PRICE_W-1:0] bid_best;
    logic [`BOOK_PRICE_W-1:0] ask_best;

    book_ctrl ctrl_i (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_req_valid     (i_req_valid),
        .i_req           (i_req),
        .i_resp_ready    (i_resp_ready),
        .i_bid_hit       (bid_hit),
        .i_ask_hit       (ask_hit),
        .i_bid_hit_slot  (bid_hit_slot),
        .i_ask_hit_slot  (ask_hit_slot),
        .i_bid_hit_qty   (bid_hit_qty),
        .i_ask_hit_qty   (ask_hit_qty),
        .i_bid_full      (bid_full),
        .i_ask_full      (ask_full),
        .i_bid_best      (bid_best),
        .i_ask_best      (ask_best),
        .i_bid_scan_done (bid_scan_done),
        .i_ask_scan_done (ask_scan_done),
        .o_busy          (o_busy),
        .o_resp_valid    (o_resp_valid),
        .o_resp          (o_resp),
        .o_bid_cmd       (bid_cmd),
        .o_ask_cmd       (ask_cmd),
        .o_stock         (stock),
        .o_slot          (slot),
        .o_entry         (entry),
        .o_dec_qty       (dec_qty),
        .o_bid_add       (bid_add),
        .o_ask_add       (ask_add),
        .o_add_price     (add_price),
        .o_bid_rescan    (bid_rescan),
        .o_ask_rescan    (ask_rescan)
    );

    book_side_mem bid_mem_i (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_cmd        (bid_cmd),
        .i_stock      (stock),
        .i_slot       (slot),
        .i_entry      (entry),
        .i_dec_qty    (dec_qty),
        .i_match_id   (entry.order_id),
        .i_scan_slot  (bid_scan_slot),
        .o_hit        (bid_hit),
        .o_hit_slot   (bid_hit_slot),
        .o_hit_qty    (bid_hit_qty),
        .o_full       (bid_full),
        .o_scan_entry (bid_scan_entry),
        .o_scan_valid (bid_scan_valid)
    );

    book_side_mem ask_mem_i (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_cmd        (ask_cmd),
        .i_stock      (stock),
        .i_slot       (slot),
        .i_entry      (entry),
        .i_dec_qty    (dec_qty),
        .i_match_id   (entry.order_id),
        .i_scan_slot  (ask_scan_slot),
        .o_hit        (ask_hit),
        .o_hit_slot   (ask_hit_slot),
        .o_hit_qty    (ask_hit_qty),
        .o_full       (ask_full),
        .o_scan_entry (ask_scan_entry),
        .o_scan_valid (ask_scan_valid)
    );

    best_price_tracker #(.IS_BID(1'b1)) bid_best_i (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_stock      (stock),
        .i_add        (bid_add),
        .i_add_price  (add_price),
        .i_rescan     (bid_rescan),
        .i_scan_entry (bid_scan_entry),
        .i_scan_valid (bid_scan_valid),
        .o_scan_slot  (bid_scan_slot),
        .o_scan_done  (bid_scan_done),
        .o_best       (bid_best)
    );

    best_price_tracker #(.IS_BID(1'b0)) ask_best_i (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_stock      (stock),
        .i_add        (ask_add),
        .i_add_price  (add_price),
        .i_rescan     (ask_rescan),
        .i_scan_entry (ask_scan_entry),
        .i_scan_valid (ask_scan_valid),
        .o_scan_slot  (ask_scan_slot),
        .o_scan_done  (ask_scan_done),
        .o_best       (ask_best)
    );

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
//////////////////////////////
// free running clock, starts low
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

endmodule

`default_nettype wire

// File: tb/order_book_properties.sv
//////////////////////////////
// handshake rules, bound to the top
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module order_book_properties (
    input logic                       i_clk,
    input logic                       i_reset_n,
    input logic                       i_resp_ready,
    input logic                       i_busy,
    input logic                       i_resp_valid,
    input order_book_pkg::book_resp_t i_resp
);

    valid_needs_busy: assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        i_resp_valid |-> i_busy
    ) else $error("response valid while the book is not busy");

    // held response must not move
    resp_held_stable: assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        i_resp_valid && !i_resp_ready |=> i_resp_valid && $stable(i_resp)
    ) else $error("response changed under back-pressure");

    // busy only drops at a taken response, so nothing new gets in
    busy_until_taken: assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        i_busy && !(i_resp_valid && i_resp_ready) |=> i_busy
    ) else $error("busy dropped before the response was taken");

endmodule

bind order_book_top order_book_properties props_i (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_resp_ready (i_resp_ready),
    .i_busy       (o_busy),
    .i_resp_valid (o_resp_valid),
    .i_resp       (o_resp)
);

`default_nettype wire

// File: tb/tb_order_book.sv
//////////////////////////////
// trace driven test of the order book
// at most 64 ops in the trace file
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "book_params.svh"

module tb_order_book;
    import order_book_pkg::*;

    localparam int MAX_OPS      = 64;
    localparam int NUM_FIELDS   = 9;
    localparam int RESET_CYCLES = 16;
    localparam int SEED         = 29361;

    logic       i_clk;
    logic       i_reset_n;
    logic       i_req_valid;
    order_req_t i_req;
    logic       i_resp_ready;
    logic       o_busy;
    logic       o_resp_valid;
    book_resp_t o_resp;

    // nine hex fields per op, see the trace file
    logic [31:0] trace [MAX_OPS * NUM_FIELDS];
    int          num_ops;
    int          timeout_limit;
    int          cycle_cnt;
    int          status_errs;
    int          bid_errs;
    int          ask_errs;
    int          other_errs;

    tb_clock_gen #(.PERIOD_NS(8)) clk_gen_i (
        .o_clk (i_clk)
    );

    order_book_top dut_i (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_req_valid  (i_req_valid),
        .i_req        (i_req),
        .i_resp_ready (i_resp_ready),
        .o_busy       (o_busy),
        .o_resp_valid (o_resp_valid),
        .o_resp       (o_resp)
    );

    function automatic string op_name(input op_t op);
        case (op)
            OP_ADD:     return "add";
            OP_CANCEL:  return "cancel";
            OP_EXECUTE: return "execute";
            default:    return "unknown";
        endcase
    endfunction

    task automatic load_trace();
        // all ones in the op field marks the end
        for (int k = 0; k < MAX_OPS * NUM_FIELDS; k++) begin
            trace[k] = 32'hFFFF_FFFF;
        end
        $readmemh("tb/order_book_trace.txt", trace);
        num_ops = 0;
        while (num_ops < MAX_OPS && trace[num_ops * NUM_FIELDS] != 32'hFFFF_FFFF) begin
            num_ops++;
        end
        assert (num_ops > 0) else begin
            $display("the trace file holds no operations");
            other_errs++;
        end
    endtask

    // called at a falling edge, returns one edge after acceptance
    task automatic send_request(input int n);
        int base;
        base           = n * NUM_FIELDS;
        i_req.op       = op_t'(trace[base][1:0]);
        i_req.side     = side_t'(trace[base + 1][0]);
        i_req.stock_id = trace[base + 2][`BOOK_STOCK_W-1:0];
        i_req.quantity = trace[base + 3][`BOOK_QTY_W-1:0];
        i_req.price    = trace[base + 4][`BOOK_PRICE_W-1:0];
        i_req.order_id = trace[base + 5][`BOOK_ID_W-1:0];
        i_req_valid    = 1'b1;
        while (o_busy) begin
            @(negedge i_clk);
        end
        @(negedge i_clk);
        i_req_valid = 1'b0;
        assert (o_busy) else begin
            $display("op %0d: the request was not accepted", n);
            other_errs++;
        end
    endtask

    task automatic take_response(input int n);
        int                       base;
        int                       delay;
        string                    name;
        book_resp_t               first;
        status_t                  exp_status;
        logic [`BOOK_STOCK_W-1:0] exp_stock;
        logic [`BOOK_PRICE_W-1:0] exp_bid;
        logic [`BOOK_PRICE_W-1:0] exp_ask;
        base       = n * NUM_FIELDS;
        name       = op_name(op_t'(trace[base][1:0]));
        exp_stock  = trace[base + 2][`BOOK_STOCK_W-1:0];
        exp_status = status_t'(trace[base + 6][1:0]);
        exp_bid    = trace[base + 7][`BOOK_PRICE_W-1:0];
        exp_ask    = trace[base + 8][`BOOK_PRICE_W-1:0];
        while (!o_resp_valid) begin
            @(negedge i_clk);
        end
        first = o_resp;
        // back-pressure before the response is taken
        delay = $urandom % 4;
        repeat (delay) begin
            @(negedge i_clk);
            assert (o_resp_valid && o_resp == first) else begin
                $display("op %0d %s: response changed or dropped before it was taken", n, name);
                other_errs++;
            end
        end
        assert (o_resp.status == exp_status) else begin
            $display("Fail op %0d %s status: expected %s, actual %s",
                     n, name, exp_status.name(), o_resp.status.name());
            status_errs++;
        end
        assert (o_resp.best_bid == exp_bid) else begin
            $display("Fail op %0d %s best bid: expected %h, actual %h",
                     n, name, exp_bid, o_resp.best_bid);
            bid_errs++;
        end
        assert (o_resp.best_ask == exp_ask) else begin
            $display("Fail op %0d %s best ask: expected %h, actual %h",
                     n, name, exp_ask, o_resp.best_ask);
            ask_errs++;
        end
        assert (o_resp.stock_id == exp_stock) else begin
            $display("Fail op %0d %s stock: expected %0d, actual %0d",
                     n, name, exp_stock, o_resp.stock_id);
            other_errs++;
        end
        i_resp_ready = 1'b1;
        @(negedge i_clk);
        i_resp_ready = 1'b0;
        assert (!o_resp_valid && !o_busy) else begin
            $display("op %0d %s: the book stayed busy after the response was taken", n, name);
            other_errs++;
        end
    endtask

    // run limit from the trace length
    always @(posedge i_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (timeout_limit != 0 && cycle_cnt >= timeout_limit) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        i_reset_n     = 1'b0;
        i_req_valid   = 1'b0;
        i_req         = '0;
        i_resp_ready  = 1'b0;
        cycle_cnt     = 0;
        timeout_limit = 0;
        status_errs   = 0;
        bid_errs      = 0;
        ask_errs      = 0;
        other_errs    = 0;
        void'($urandom(SEED));
        load_trace();
        timeout_limit = RESET_CYCLES + num_ops * (`BOOK_DEPTH + 8);
        repeat (RESET_CYCLES) @(negedge i_clk);
        i_reset_n = 1'b1;
        @(negedge i_clk);
        for (int n = 0; n < num_ops; n++) begin
            send_request(n);
            take_response(n);
        end
        $display("errors: status %0d, best bid %0d, best ask %0d, other %0d",
                 status_errs, bid_errs, ask_errs, other_errs);
        if (status_errs + bid_errs + ask_errs + other_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/order_book_trace.txt
// op (0 add, 1 cancel, 2 execute), side (1 bid, 0 ask), stock, qty, price, id
// expected status (0 ok, 1 not found, 2 full), best bid, best ask; all hex
0 1 0 0064 000003E8 00000001 0 000003E8 FFFFFFFF
0 1 0 0032 000003F2 00000002 0 000003F2 FFFFFFFF
0 0 0 0050 000003FC 00000003 0 000003F2 000003FC
0 0 0 003C 000003F7 00000004 0 000003F2 000003F7
0 1 1 000A 000001F4 00000005 0 000001F4 FFFFFFFF
0 0 1 0014 00000208 00000006 0 000001F4 00000208
1 1 2 0000 00000000 00000063 1 00000000 FFFFFFFF
1 1 0 0000 00000000 00000002 0 000003E8 000003F7
0 1 0 001E 000003DE 00000007 0 000003E8 000003F7
1 1 0 0000 00000000 00000007 0 000003E8 000003F7
2 0 0 0014 00000000 00000004 0 000003E8 000003F7
2 0 0 0028 00000000 00000004 0 000003E8 000003FC
2 0 0 0005 00000000 0000004D 1 000003E8 000003FC
1 0 0 0000 00000000 00000001 1 000003E8 000003FC
2 1 1 0005 00000000 00000006 1 000001F4 00000208
0 0 3 0001 0000090A 00000010 0 00000000 0000090A
0 0 3 0001 00000909 00000011 0 00000000 00000909
0 0 3 0001 00000908 00000012 0 00000000 00000908
0 0 3 0001 00000907 00000013 0 00000000 00000907
0 0 3 0001 00000906 00000014 0 00000000 00000906
0 0 3 0001 00000905 00000015 0 00000000 00000905
0 0 3 0001 00000904 00000016 0 00000000 00000904
0 0 3 0001 00000903 00000017 0 00000000 00000903
0 0 3 0001 00000902 00000018 0 00000000 00000902
0 0 3 0001 00000901 00000019 0 00000000 00000901
0 0 3 0001 00000900 0000001A 2 00000000 00000901
1 0 3 0000 00000000 00000019 0 00000000 00000902
0 0 3 0001 00000900 0000001A 0 00000000 00000900

// File: project.f
+incdir+common
common/order_book_pkg.sv
book/book_side_mem.sv
book/best_price_tracker.sv
book/book_ctrl.sv
hdl/order_book_top.sv
tb/tb_clock_gen.sv
tb/order_book_properties.sv
tb/tb_order_book.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_order_book
FILELIST   := project.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
